/* flist.f */
+incdir+hdl
hdl/excp_pkg.sv
hdl/csr_trap_if.sv
hdl/int_sampler.sv
hdl/trap_decide.sv
hdl/priv_csr_file.sv
hdl/trap_unit_top.sv
verif/tb_clk_gen.sv
verif/trap_unit_sva.sv
verif/trap_unit_tb.sv

/* hdl/csr_trap_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface csr_trap_if;
    import excp_pkg::*;

    // current register values, owned by the csr file.
    word_t crmd;
    word_t prmd;
    word_t ecfg;
    virt_t era;
    virt_t badv;
    word_t tlbehi;
    virt_t eentry;
    virt_t tlbrentry;

    // trap update, a one-cycle strobe from the decision stage.
    logic   trap_we;
    word_t  trap_crmd;
    word_t  trap_prmd;
    ecode_t trap_ecode;
    virt_t  trap_era;
    virt_t  trap_badv;
    word_t  trap_tlbehi;

    modport csr (
        output crmd, prmd, ecfg, era, badv, tlbehi, eentry, tlbrentry,
        input  trap_we, trap_crmd, trap_prmd, trap_ecode, trap_era, trap_badv, trap_tlbehi
    );

    modport decide (
        input  crmd, prmd, ecfg, era, badv, tlbehi, eentry, tlbrentry,
        output trap_we, trap_crmd, trap_prmd, trap_ecode, trap_era, trap_badv, trap_tlbehi
    );

endinterface

`default_nettype wire

/* hdl/excp_cfg.svh */
`ifndef EXCP_CFG_SVH
`define EXCP_CFG_SVH

// data and virtual address width of the core.
`define XLEN 32

// interrupt vector width, matching the estat.is and ecfg.lie fields.
`define INT_NUM 13

// exception entry used until software programs eentry.
`define RST_EENTRY 32'h1c00_0180

// tlb refill entry used until software programs tlbrentry.
`define RST_TLBRENTRY 32'h1c00_1000

`endif

/* hdl/excp_pkg.sv */
`default_nettype none

`include "excp_cfg.svh"

package excp_pkg;

    typedef logic [`XLEN-1:0]    virt_t;
    typedef logic [`XLEN-1:0]    word_t;
    typedef logic [`INT_NUM-1:0] int_vec_t;   // bits 1:0 swi, 9:2 hwi, 11 timer.
    typedef logic [1:0]          plv_t;

    localparam plv_t KERNEL = 2'd0;

    // adem gets a code of its own because there is no subcode field here.
    typedef enum logic [5:0] {
        INT  = 6'h00,
        PIL  = 6'h01,
        PIS  = 6'h02,
        PIF  = 6'h03,
        PME  = 6'h04,
        PPI  = 6'h07,
        ADEF = 6'h08,
        ALE  = 6'h09,
        ADEM = 6'h0a,
        SYS  = 6'h0b,
        BRK  = 6'h0c,
        INE  = 6'h0d,
        TLBR = 6'h3f
    } ecode_t;

    typedef enum logic [3:0] {
        CRMD      = 4'd0,
        PRMD      = 4'd1,
        ECFG      = 4'd2,
        ESTAT     = 4'd3,
        ERA       = 4'd4,
        BADV      = 4'd5,
        EENTRY    = 4'd6,
        TLBEHI    = 4'd7,
        TLBRENTRY = 4'd8
    } csr_addr_t;

    // crmd fields.
    localparam int CRMD_PLV_LO = 0;
    localparam int CRMD_IE     = 2;
    localparam int CRMD_DA     = 3;
    localparam int CRMD_PG     = 4;

    // prmd fields.
    localparam int PRMD_PPLV_LO = 0;
    localparam int PRMD_PIE     = 2;

    localparam int ESTAT_ECODE_LO = 16;   // ecode sits in bits 21:16.
    localparam int ECFG_LIE_LO    = 0;
    localparam int TLBEHI_VPPN_LO = 13;   // vppn fills bits 31:13.

    // bits that software may write, everything else reads back as zero.
    localparam word_t CRMD_WMASK   = 32'h0000_001f;
    localparam word_t PRMD_WMASK   = 32'h0000_0007;
    localparam word_t ECFG_WMASK   = 32'h0000_1fff;
    localparam word_t TLBEHI_WMASK = 32'hffff_e000;

endpackage

`default_nettype wire

/* hdl/int_sampler.sv */
`timescale 1ns/100ps
`default_nettype none

module int_sampler (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            ti_in,
    input  wire logic            ti_clr,
    input  wire logic [1:0]      swi_in,
    input  wire logic [1:0]      swi_clr,
    input  wire logic [7:0]      hwi_in,
    output excp_pkg::int_vec_t   pending
);
    import excp_pkg::*;

    int_vec_t line_vec;
    int_vec_t clr_vec;
    int_vec_t sticky;
    int_vec_t sticky_d;

    // bits 10 and 12 have no source in this core.
    assign line_vec = {1'b0, ti_in, 1'b0, hwi_in, swi_in};
    assign clr_vec  = {1'b0, ti_clr, 1'b0, 8'b0, swi_clr};   // hwi has no clear input.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sticky   <= '0;
            sticky_d <= '0;
        end else begin
            sticky   <= ~clr_vec & (line_vec | sticky);
            sticky_d <= sticky;
        end
    end

    // the second register lines the vector up with the retire stage.
    assign pending = sticky_d;

endmodule

`default_nettype wire

/* hdl/priv_csr_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "excp_cfg.svh"

module priv_csr_file (
    input  wire logic            clk,
    input  wire logic            rst_n,
    csr_trap_if.csr              csr,
    input  wire logic            csr_wr_valid,
    input  excp_pkg::csr_addr_t  csr_wr_addr,
    input  excp_pkg::word_t      csr_wr_data,
    input  excp_pkg::csr_addr_t  csr_rd_addr,
    output excp_pkg::word_t      csr_rd_data
);
    import excp_pkg::*;

    // direct address mode, kernel level, interrupts off.
    localparam word_t CRMD_RST = word_t'(1) << CRMD_DA;

    word_t  crmd;
    word_t  prmd;
    word_t  ecfg;
    ecode_t estat_ecode;
    virt_t  era;
    virt_t  badv;
    virt_t  eentry;
    word_t  tlbehi;
    virt_t  tlbrentry;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd        <= CRMD_RST;
            prmd        <= '0;
            ecfg        <= '0;
            estat_ecode <= INT;
            era         <= '0;
            badv        <= '0;
            eentry      <= `RST_EENTRY;
            tlbehi      <= '0;
            tlbrentry   <= `RST_TLBRENTRY;
        end else if (csr.trap_we) begin
            // a trap in the same cycle drops the software write.
            crmd        <= csr.trap_crmd;
            prmd        <= csr.trap_prmd;
            estat_ecode <= csr.trap_ecode;
            era         <= csr.trap_era;
            badv        <= csr.trap_badv;
            tlbehi      <= csr.trap_tlbehi;
        end else if (csr_wr_valid) begin
            case (csr_wr_addr)
                CRMD:      crmd      <= csr_wr_data & CRMD_WMASK;
                PRMD:      prmd      <= csr_wr_data & PRMD_WMASK;
                ECFG:      ecfg      <= csr_wr_data & ECFG_WMASK;
                ERA:       era       <= csr_wr_data;
                BADV:      badv      <= csr_wr_data;
                EENTRY:    eentry    <= csr_wr_data;
                TLBEHI:    tlbehi    <= csr_wr_data & TLBEHI_WMASK;
                TLBRENTRY: tlbrentry <= csr_wr_data;
                default: begin
                    // estat is only written by traps.
                end
            endcase
        end
    end

    always_comb begin
        case (csr_rd_addr)
            CRMD:      csr_rd_data = crmd;
            PRMD:      csr_rd_data = prmd;
            ECFG:      csr_rd_data = ecfg;
            ESTAT:     csr_rd_data = word_t'(estat_ecode) << ESTAT_ECODE_LO;
            ERA:       csr_rd_data = era;
            BADV:      csr_rd_data = badv;
            EENTRY:    csr_rd_data = eentry;
            TLBEHI:    csr_rd_data = tlbehi;
            TLBRENTRY: csr_rd_data = tlbrentry;
            default:   csr_rd_data = '0;   // unmapped addresses read as zero.
        endcase
    end

    assign csr.crmd      = crmd;
    assign csr.prmd      = prmd;
    assign csr.ecfg      = ecfg;
    assign csr.era       = era;
    assign csr.badv      = badv;
    assign csr.tlbehi    = tlbehi;
    assign csr.eentry    = eentry;
    assign csr.tlbrentry = tlbrentry;

endmodule

`default_nettype wire

/* hdl/trap_decide.sv */
`timescale 1ns/100ps
`default_nettype none

`include "excp_cfg.svh"

module trap_decide (
    input  wire logic               retire_valid,
    input  wire logic               retire_excp,
    input  excp_pkg::virt_t         retire_pc,
    input  excp_pkg::virt_t         retire_badv,
    input  excp_pkg::ecode_t        retire_ecode,
    input  excp_pkg::int_vec_t      pending,
    csr_trap_if.decide              csr,
    output logic                    redirect_valid,
    output excp_pkg::virt_t         redirect_pc,
    output logic                    flush,
    output logic                    wake
);
    import excp_pkg::*;

    int_vec_t lie;
    logic     cur_ie;
    plv_t     cur_plv;
    logic     int_hit;
    logic     take_int;
    logic     take_excp;
    logic     trap_taken;
    logic     is_tlbr;
    logic     wr_badv;
    logic     wr_vppn;

    assign lie     = csr.ecfg[ECFG_LIE_LO +: `INT_NUM];
    assign cur_ie  = csr.crmd[CRMD_IE];
    assign cur_plv = csr.crmd[CRMD_PLV_LO +: $bits(plv_t)];

    // an enabled interrupt is waiting, regardless of what retires.
    assign int_hit = cur_ie & (|(pending & lie));
    assign wake    = int_hit;

    assign take_int   = retire_valid & int_hit;               // a bubble never traps.
    assign take_excp  = retire_valid & retire_excp & ~take_int;
    assign trap_taken = take_int | take_excp;

    assign is_tlbr = (retire_ecode == TLBR);

    assign redirect_valid = trap_taken;
    assign flush          = trap_taken;
    assign redirect_pc    = (take_excp && is_tlbr) ? csr.tlbrentry : csr.eentry;

    // memory faults report the address, and the page faults also report the page.
    always_comb begin
        wr_badv = 1'b0;
        wr_vppn = 1'b0;
        case (retire_ecode)
            TLBR, PIL, PIS, PIF, PME, PPI: begin
                wr_badv = 1'b1;
                wr_vppn = 1'b1;
            end
            ADEF, ADEM, ALE: begin
                wr_badv = 1'b1;
            end
            default: begin
                wr_badv = 1'b0;
            end
        endcase
    end

    always_comb begin
        csr.trap_we     = trap_taken;
        csr.trap_crmd   = csr.crmd;
        csr.trap_prmd   = csr.prmd;
        csr.trap_ecode  = take_int ? INT : retire_ecode;
        csr.trap_era    = csr.era;
        csr.trap_badv   = csr.badv;
        csr.trap_tlbehi = csr.tlbehi;

        if (trap_taken) begin
            csr.trap_crmd[CRMD_PLV_LO +: $bits(plv_t)]  = KERNEL;
            csr.trap_crmd[CRMD_IE]                      = 1'b0;
            csr.trap_prmd[PRMD_PPLV_LO +: $bits(plv_t)] = cur_plv;
            csr.trap_prmd[PRMD_PIE]                     = cur_ie;
            csr.trap_era                                = retire_pc;
        end

        if (take_excp) begin
            if (is_tlbr) begin
                // refill runs in direct address mode.
                csr.trap_crmd[CRMD_DA] = 1'b1;
                csr.trap_crmd[CRMD_PG] = 1'b0;
            end
            if (wr_badv) begin
                csr.trap_badv = retire_badv;
            end
            if (wr_vppn) begin
                csr.trap_tlbehi[`XLEN-1:TLBEHI_VPPN_LO] = retire_badv[`XLEN-1:TLBEHI_VPPN_LO];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/trap_unit_top.sv */
`timescale 1ns/100ps
`default_nettype none

module trap_unit_top (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            ti_in,
    input  wire logic            ti_clr,
    input  wire logic [1:0]      swi_in,
    input  wire logic [1:0]      swi_clr,
    input  wire logic [7:0]      hwi_in,
    input  wire logic            retire_valid,
    input  wire logic            retire_excp,
    input  excp_pkg::virt_t      retire_pc,
    input  excp_pkg::ecode_t     retire_ecode,
    input  excp_pkg::virt_t      retire_badv,
    input  wire logic            csr_wr_valid,
    input  excp_pkg::csr_addr_t  csr_wr_addr,
    input  excp_pkg::word_t      csr_wr_data,
    input  excp_pkg::csr_addr_t  csr_rd_addr,
    output excp_pkg::word_t      csr_rd_data,
    output logic                 redirect_valid,
    output excp_pkg::virt_t      redirect_pc,
    output logic                 flush,
    output logic                 wake,
    output excp_pkg::int_vec_t   int_status
);

    csr_trap_if csr_bus ();

    // int_status doubles as the pending vector seen by the decision stage.
    int_sampler u_int_sampler (
        .clk     (clk),
        .rst_n   (rst_n),
        .ti_in   (ti_in),
        .ti_clr  (ti_clr),
        .swi_in  (swi_in),
        .swi_clr (swi_clr),
        .hwi_in  (hwi_in),
        .pending (int_status)
    );

    trap_decide u_trap_decide (
        .retire_valid   (retire_valid),
        .retire_excp    (retire_excp),
        .retire_pc      (retire_pc),
        .retire_badv    (retire_badv),
        .retire_ecode   (retire_ecode),
        .pending        (int_status),
        .csr            (csr_bus),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush),
        .wake           (wake)
    );

    priv_csr_file u_priv_csr_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr          (csr_bus),
        .csr_wr_valid (csr_wr_valid),
        .csr_wr_addr  (csr_wr_addr),
        .csr_wr_data  (csr_wr_data),
        .csr_rd_addr  (csr_rd_addr),
        .csr_rd_data  (csr_rd_data)
    );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period.
    end

    // reset covers three rising edges and is released just after the third.
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/trap_unit_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module trap_unit_sva (
    input wire logic               clk,
    input wire logic               rst_n,
    input wire logic               retire_valid,
    input wire logic               redirect_valid,
    input wire logic               flush,
    input wire excp_pkg::int_vec_t int_status
);

    // every redirect flushes the pipeline and nothing else does.
    flush_matches_redirect: assert property (
        @(posedge clk) disable iff (!rst_n) flush == redirect_valid
    ) else $error("flush differs from redirect_valid");

    flush_needs_retire: assert property (
        @(posedge clk) disable iff (!rst_n) flush |-> retire_valid
    ) else $error("flush raised in a cycle without a retiring instruction");

    // bits 10 and 12 have no interrupt source.
    reserved_int_bits_zero: assert property (
        @(posedge clk) disable iff (!rst_n) (int_status[10] == 1'b0) && (int_status[12] == 1'b0)
    ) else $error("reserved int_status bit set");

endmodule

bind trap_unit_top trap_unit_sva u_trap_unit_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .retire_valid   (retire_valid),
    .redirect_valid (redirect_valid),
    .flush          (flush),
    .int_status     (int_status)
);

`default_nettype wire

/* verif/trap_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "excp_cfg.svh"

module trap_unit_tb;
    import excp_pkg::*;

    typedef struct packed {
        word_t    crmd_set;
        word_t    ecfg_set;
        int_vec_t lines;    // interrupt lines, high for one cycle.
        int_vec_t clears;
        logic     rv;
        logic     rexcp;
        ecode_t   ecode;
    } stim_t;

    typedef struct packed {
        logic  trap;
        logic  wake;
        virt_t pc;
    } expect_t;

    logic      clk;
    logic      rst_n;
    logic      ti_in;
    logic      ti_clr;
    logic [1:0] swi_in;
    logic [1:0] swi_clr;
    logic [7:0] hwi_in;
    logic      retire_valid;
    logic      retire_excp;
    virt_t     retire_pc;
    virt_t     retire_badv;
    ecode_t    retire_ecode;
    logic      csr_wr_valid;
    csr_addr_t csr_wr_addr;
    csr_addr_t csr_rd_addr;
    word_t     csr_wr_data;
    word_t     csr_rd_data;
    logic      redirect_valid;
    logic      flush;
    logic      wake;
    virt_t     redirect_pc;
    int_vec_t  int_status;

    // reference copy of the privileged state.
    word_t    m_crmd;
    word_t    m_prmd;
    word_t    m_ecfg;
    ecode_t   m_ecode;
    virt_t    m_era;
    virt_t    m_badv;
    word_t    m_tlbehi;
    virt_t    m_eentry;
    virt_t    m_tlbrentry;
    int_vec_t m_pend;

    stim_t  stims[$];
    string  names[$];
    string  cur_name;
    logic   test_failed;
    int     pass_count;
    int     fail_count;
    integer seed;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    trap_unit_top i_trap_unit_top (.*);

    task add_test(input string name, input word_t crmd_set, input word_t ecfg_set,
                  input int_vec_t lines, input int_vec_t clears, input logic rv,
                  input logic rexcp, input ecode_t ecode);
        stim_t s;
        s = '{crmd_set, ecfg_set, lines, clears, rv, rexcp, ecode};
        stims.push_back(s);
        names.push_back(name);
    endtask

    task write_csr(input csr_addr_t addr, input word_t data);
        @(posedge clk);
        #1;
        csr_wr_valid = 1'b1;
        csr_wr_addr  = addr;
        csr_wr_data  = data;
        @(posedge clk);
        #1;
        csr_wr_valid = 1'b0;
    endtask

    task read_csr(input csr_addr_t addr, output word_t data);
        csr_rd_addr = addr;
        #0.3;
        data = csr_rd_data;
    endtask

    task check_value(input string field, input word_t exp_v, input word_t act_v);
        if (exp_v !== act_v) begin
            if (!test_failed) begin
                $display("mismatch %s %s expected %h actual %h", cur_name, field, exp_v, act_v);
            end
            test_failed = 1'b1;
        end
    endtask

    // applies the retire rules to the reference state.
    task predict(input stim_t s, input virt_t pc, input virt_t bv, output expect_t e);
        logic hit;
        logic take_int;
        logic take_excp;
        hit       = m_crmd[CRMD_IE] && ((m_pend & m_ecfg[12:0]) != '0);
        take_int  = s.rv && hit;
        take_excp = s.rv && s.rexcp && !take_int;
        e.trap = take_int || take_excp;
        e.wake = hit;
        e.pc   = (take_excp && s.ecode == TLBR) ? m_tlbrentry : m_eentry;
        if (e.trap) begin
            m_prmd           = '0;
            m_prmd[1:0]      = m_crmd[1:0];
            m_prmd[PRMD_PIE] = m_crmd[CRMD_IE];
            m_crmd[1:0]      = KERNEL;
            m_crmd[CRMD_IE]  = 1'b0;
            m_era            = pc;
            m_ecode          = take_int ? INT : s.ecode;
        end
        if (take_excp) begin
            if (s.ecode == TLBR) begin
                m_crmd[CRMD_DA] = 1'b1;
                m_crmd[CRMD_PG] = 1'b0;
            end
            if (s.ecode inside {TLBR, ADEF, ADEM, ALE, PIL, PIS, PIF, PME, PPI}) begin
                m_badv = bv;
            end
            if (s.ecode inside {TLBR, PIL, PIS, PIF, PME, PPI}) begin
                m_tlbehi[31:13] = bv[31:13];
            end
        end
    endtask

    task run_test(input int idx);
        stim_t    s;
        expect_t  e;
        virt_t    pc;
        virt_t    bv;
        word_t    rd;
        int       n;
        int       exp_n;
        int_vec_t old_pend;
        s           = stims[idx];
        cur_name    = names[idx];
        test_failed = 1'b0;
        pc          = $random(seed);
        bv          = $random(seed);
        write_csr(CRMD, s.crmd_set);
        m_crmd = s.crmd_set & 32'h0000_001f;   // plv, ie, da and pg only.
        write_csr(ECFG, s.ecfg_set);
        m_ecfg = s.ecfg_set & 32'h0000_1fff;
        swi_in  = s.lines[1:0];
        hwi_in  = s.lines[9:2];
        ti_in   = s.lines[11];
        swi_clr = s.clears[1:0];
        ti_clr  = s.clears[11];
        old_pend = m_pend;
        m_pend  = ~(s.clears & 13'h803) & (s.lines | m_pend);   // hardware lines have no clear.
        @(posedge clk);
        #1;
        swi_in  = '0;
        hwi_in  = '0;
        ti_in   = 1'b0;
        swi_clr = '0;
        ti_clr  = 1'b0;
        n = 0;
        while (int_status !== m_pend && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (int_status !== m_pend) begin
            $display("timeout in %s waiting for int_status to become %h", cur_name, m_pend);
            test_failed = 1'b1;
        end
        // a changed line or clear is sampled at one edge and shows after the next.
        exp_n = (m_pend != old_pend) ? 1 : 0;
        check_value("int_status latency", exp_n, n);
        retire_valid = s.rv;
        retire_excp  = s.rexcp;
        retire_ecode = s.ecode;
        retire_pc    = pc;
        retire_badv  = bv;
        predict(s, pc, bv, e);
        #2;
        check_value("redirect_valid", e.trap, redirect_valid);
        check_value("flush", e.trap, flush);
        check_value("wake", e.wake, wake);
        if (e.trap) begin
            check_value("redirect_pc", e.pc, redirect_pc);
        end
        @(posedge clk);
        #1;
        retire_valid = 1'b0;
        retire_excp  = 1'b0;
        check_value("int_status", m_pend, int_status);
        read_csr(ERA, rd);
        check_value("era", m_era, rd);
        read_csr(ESTAT, rd);
        check_value("estat.ecode", m_ecode, rd[21:16]);
        read_csr(BADV, rd);
        check_value("badv", m_badv, rd);
        read_csr(CRMD, rd);
        check_value("crmd", m_crmd, rd);
        read_csr(PRMD, rd);
        check_value("prmd", m_prmd, rd);
        read_csr(TLBEHI, rd);
        check_value("tlbehi", m_tlbehi, rd);
        if (test_failed) begin
            fail_count++;
        end else begin
            pass_count++;
            $display("ok %s", cur_name);
        end
    endtask

    initial begin
        int    i;
        int    n;
        word_t rd;
        ti_in        = 1'b0;
        ti_clr       = 1'b0;
        swi_in       = '0;
        swi_clr      = '0;
        hwi_in       = '0;
        retire_valid = 1'b0;
        retire_excp  = 1'b0;
        retire_pc    = '0;
        retire_badv  = '0;
        retire_ecode = INT;
        csr_wr_valid = 1'b0;
        csr_wr_addr  = CRMD;
        csr_wr_data  = '0;
        csr_rd_addr  = CRMD;
        seed         = 32'hc10280ea;
        pass_count   = 0;
        fail_count   = 0;
        m_crmd       = 32'h0000_0008;   // plv kernel, ie 0, da 1, pg 0.
        m_prmd       = '0;
        m_ecfg       = '0;
        m_ecode      = INT;
        m_era        = '0;
        m_badv       = '0;
        m_tlbehi     = '0;
        m_eentry     = `RST_EENTRY;
        m_tlbrentry  = `RST_TLBRENTRY;
        m_pend       = '0;

        //        name             crmd    ecfg     lines    clears   rv    excp  ecode
        add_test("syscall",        32'h17, 32'h000, 13'h000, 13'h000, 1'b1, 1'b1, SYS);
        add_test("tlb_refill",     32'h17, 32'h000, 13'h000, 13'h000, 1'b1, 1'b1, TLBR);
        add_test("page_inv_load",  32'h17, 32'h000, 13'h000, 13'h000, 1'b1, 1'b1, PIL);
        add_test("misaligned",     32'h17, 32'h000, 13'h000, 13'h000, 1'b1, 1'b1, ALE);
        add_test("hwi_over_excp",  32'h07, 32'h010, 13'h010, 13'h000, 1'b1, 1'b1, ALE);
        add_test("ie_clear",       32'h03, 32'h010, 13'h000, 13'h000, 1'b1, 1'b0, INT);
        add_test("lie_masked",     32'h07, 32'h000, 13'h000, 13'h000, 1'b1, 1'b0, INT);
        add_test("bubble_wake",    32'h07, 32'h010, 13'h000, 13'h000, 1'b0, 1'b0, INT);
        add_test("swi_sticky",     32'h03, 32'h000, 13'h001, 13'h000, 1'b1, 1'b0, INT);
        add_test("swi_clear",      32'h07, 32'h001, 13'h000, 13'h001, 1'b1, 1'b0, INT);
        add_test("timer_int",      32'h07, 32'h800, 13'h800, 13'h000, 1'b1, 1'b1, INE);

        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            fail_count++;
        end
        @(posedge clk);
        #1;
        cur_name    = "reset_state";
        test_failed = 1'b0;
        read_csr(CRMD, rd);
        check_value("crmd", m_crmd, rd);
        read_csr(EENTRY, rd);
        check_value("eentry", m_eentry, rd);
        check_value("int_status", '0, int_status);
        check_value("wake", '0, wake);
        check_value("redirect_valid", '0, redirect_valid);
        check_value("flush", '0, flush);
        if (test_failed) begin
            fail_count++;
        end else begin
            pass_count++;
            $display("ok %s", cur_name);
        end

        write_csr(EENTRY, 32'h1c00_4000);
        m_eentry = 32'h1c00_4000;
        write_csr(TLBRENTRY, 32'h1c00_6000);
        m_tlbrentry = 32'h1c00_6000;
        for (i = 0; i < stims.size(); i++) begin
            run_test(i);
        end

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
